/* rot_pkg.sv */
`default_nettype none

package rot_pkg;

    // Image geometry.
    localparam int IMAGE_SIZE = 60;
    localparam int IMAGE_COOR_BIT = 6;
    localparam int VEC_WIDTH = IMAGE_COOR_BIT + 1;

    // Angle in whole degrees, -180 to 180.
    localparam int ANG_WIDTH = 9;

    // CORDIC word format. Vector and angle both carry 12 fraction bits.
    localparam int VEC_PROCESS_WIDTH = 22;
    localparam int VEC_FRAC_BITS = 12;
    localparam int ANG_FRAC_BITS = 12;
    localparam int CORDIC_STAGES = 14;

    // Pop to registered result: decode, pre-rotation, stages, result.
    localparam int ROT_LATENCY = CORDIC_STAGES + 3;

    // Credit channels.
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int CMD_PTR_BITS = $clog2(CMD_FIFO_DEPTH);
    localparam int CMD_CNT_BITS = $clog2(CMD_FIFO_DEPTH + 1);
    localparam int RES_CREDITS = 4;
    localparam int RES_CNT_BITS = $clog2(RES_CREDITS + 1);

    // 1/K = 0.607253 with 14 fraction bits.
    localparam int GAIN_FRAC_BITS = 14;
    localparam logic [GAIN_FRAC_BITS:0] CORDIC_GAIN_INV = 15'd9949;

    typedef enum logic [0:0] {
        OP_SET_ANGLE = 1'b0,
        OP_ROTATE    = 1'b1
    } rot_op_e;

    // atan(2^-i) in degrees, scaled by 2^ANG_FRAC_BITS.
    function automatic logic signed [VEC_PROCESS_WIDTH-1:0] cordic_atan(input int i);
        logic signed [VEC_PROCESS_WIDTH-1:0] a;
        case (i)
            0:       a = 22'sd184320;
            1:       a = 22'sd108810;
            2:       a = 22'sd57492;
            3:       a = 22'sd29184;
            4:       a = 22'sd14649;
            5:       a = 22'sd7331;
            6:       a = 22'sd3667;
            7:       a = 22'sd1833;
            8:       a = 22'sd917;
            9:       a = 22'sd458;
            10:      a = 22'sd229;
            11:      a = 22'sd115;
            12:      a = 22'sd57;
            13:      a = 22'sd29;
            default: a = 22'sd0;
        endcase
        return a;
    endfunction

endpackage

`default_nettype wire

/* coor_decode.sv */
`default_nettype none

module coor_decode import rot_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_cmd_valid,
    input  rot_op_e                     i_cmd_op,
    input  logic [IMAGE_COOR_BIT-1:0]   i_cmd_h,
    input  logic [IMAGE_COOR_BIT-1:0]   i_cmd_v,
    input  logic signed [ANG_WIDTH-1:0] i_cmd_angle,
    input  logic                        i_issue_ok,
    output logic                        o_cmd_credit,
    output logic                        o_issue,
    output logic signed [VEC_WIDTH-1:0] o_x,
    output logic signed [VEC_WIDTH-1:0] o_y,
    output logic signed [ANG_WIDTH-1:0] o_angle
);

    rot_op_e                     fifo_op  [CMD_FIFO_DEPTH];
    logic [IMAGE_COOR_BIT-1:0]   fifo_h   [CMD_FIFO_DEPTH];
    logic [IMAGE_COOR_BIT-1:0]   fifo_v   [CMD_FIFO_DEPTH];
    logic signed [ANG_WIDTH-1:0] fifo_ang [CMD_FIFO_DEPTH];

    logic [CMD_PTR_BITS-1:0]     wr_ptr;
    logic [CMD_PTR_BITS-1:0]     rd_ptr;
    logic [CMD_CNT_BITS-1:0]     count;
    logic                        pop;
    logic signed [VEC_WIDTH+1:0] x_cent;
    logic signed [VEC_WIDTH+1:0] y_cent;

    // Pop only when the result side has a free slot.
    assign pop = (count != '0) && i_issue_ok;

    // Centred, doubled vector of the head entry.
    assign x_cent = $signed({2'b00, fifo_h[rd_ptr], 1'b1}) - (VEC_WIDTH+2)'(IMAGE_SIZE);
    assign y_cent = (VEC_WIDTH+2)'(IMAGE_SIZE - 1) - $signed({2'b00, fifo_v[rd_ptr], 1'b0});

    // Storage.
    always_ff @(posedge i_clk) begin
        if (i_cmd_valid) begin
            fifo_op[wr_ptr]  <= i_cmd_op;
            fifo_h[wr_ptr]   <= i_cmd_h;
            fifo_v[wr_ptr]   <= i_cmd_v;
            fifo_ang[wr_ptr] <= i_cmd_angle;
        end
    end

    // Pointers and occupancy; producer credits prevent overflow.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CMD_CNT_BITS'(i_cmd_valid) - CMD_CNT_BITS'(pop);
        end
    end

    // Credit return, issue and angle register.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_cmd_credit <= 1'b0;
            o_issue      <= 1'b0;
            o_angle      <= '0;
        end else begin
            o_cmd_credit <= pop;
            o_issue      <= pop && (fifo_op[rd_ptr] == OP_ROTATE);
            if (pop && (fifo_op[rd_ptr] == OP_SET_ANGLE)) begin
                o_angle <= fifo_ang[rd_ptr];
            end
        end
    end

    // Vector payload.
    always_ff @(posedge i_clk) begin
        if (pop) begin
            o_x <= x_cent[VEC_WIDTH-1:0];
            o_y <= y_cent[VEC_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

/* cordic_execute.sv */
`default_nettype none

module cordic_execute import rot_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  logic signed [VEC_WIDTH-1:0] i_x,
    input  logic signed [VEC_WIDTH-1:0] i_y,
    input  logic signed [ANG_WIDTH-1:0] i_angle,
    output logic                        o_valid,
    output logic signed [VEC_WIDTH-1:0] o_x,
    output logic signed [VEC_WIDTH-1:0] o_y
);

    localparam int LAST = CORDIC_STAGES - 1;

    logic signed [VEC_PROCESS_WIDTH-1:0] x_ext;
    logic signed [VEC_PROCESS_WIDTH-1:0] y_ext;
    logic signed [VEC_PROCESS_WIDTH-1:0] pre_x;
    logic signed [VEC_PROCESS_WIDTH-1:0] pre_y;
    logic signed [VEC_PROCESS_WIDTH-1:0] pre_z;
    logic signed [ANG_WIDTH-1:0]         res_deg;

    logic signed [VEC_PROCESS_WIDTH-1:0] x_s [CORDIC_STAGES];
    logic signed [VEC_PROCESS_WIDTH-1:0] y_s [CORDIC_STAGES];
    logic signed [VEC_PROCESS_WIDTH-1:0] z_s [CORDIC_STAGES];
    logic [CORDIC_STAGES-1:0]            v_s;

    logic signed [VEC_PROCESS_WIDTH-1:0] x_last;
    logic signed [VEC_PROCESS_WIDTH-1:0] y_last;

    // Gain compensation, rounding to whole units and saturation to VEC_WIDTH.
    // Saturated values still land outside the image, so the flag stays correct.
    function automatic logic signed [VEC_WIDTH-1:0] scale_round(
        input logic signed [VEC_PROCESS_WIDTH-1:0] v
    );
        logic signed [VEC_PROCESS_WIDTH+GAIN_FRAC_BITS+1:0] prod;
        logic signed [VEC_PROCESS_WIDTH+GAIN_FRAC_BITS+1:0] q;
        prod = v * $signed({1'b0, CORDIC_GAIN_INV});
        q = (prod + (1 <<< (GAIN_FRAC_BITS + VEC_FRAC_BITS - 1)))
            >>> (GAIN_FRAC_BITS + VEC_FRAC_BITS);
        if (q > (2 ** (VEC_WIDTH - 1)) - 1) begin
            return (VEC_WIDTH)'((2 ** (VEC_WIDTH - 1)) - 1);
        end else if (q < -(2 ** (VEC_WIDTH - 1))) begin
            return (VEC_WIDTH)'(-(2 ** (VEC_WIDTH - 1)));
        end
        return q[VEC_WIDTH-1:0];
    endfunction

    // Quadrant pre-rotation leaves a residual within +-90 degrees.
    always_comb begin
        x_ext = {{(VEC_PROCESS_WIDTH-VEC_WIDTH){i_x[VEC_WIDTH-1]}}, i_x} <<< VEC_FRAC_BITS;
        y_ext = {{(VEC_PROCESS_WIDTH-VEC_WIDTH){i_y[VEC_WIDTH-1]}}, i_y} <<< VEC_FRAC_BITS;
        if (i_angle > 9'sd90) begin
            pre_x   = -y_ext;
            pre_y   = x_ext;
            res_deg = i_angle - 9'sd90;
        end else if (i_angle < -9'sd90) begin
            pre_x   = y_ext;
            pre_y   = -x_ext;
            res_deg = i_angle + 9'sd90;
        end else begin
            pre_x   = x_ext;
            pre_y   = y_ext;
            res_deg = i_angle;
        end
        pre_z = {{(VEC_PROCESS_WIDTH-ANG_WIDTH){res_deg[ANG_WIDTH-1]}}, res_deg} <<< ANG_FRAC_BITS;
    end

    // Final micro-rotation, feeding the gain stage.
    always_comb begin
        if (z_s[LAST] >= 0) begin
            x_last = x_s[LAST] - (y_s[LAST] >>> LAST);
            y_last = y_s[LAST] + (x_s[LAST] >>> LAST);
        end else begin
            x_last = x_s[LAST] + (y_s[LAST] >>> LAST);
            y_last = y_s[LAST] - (x_s[LAST] >>> LAST);
        end
    end

    // Datapath pipeline.
    always_ff @(posedge i_clk) begin
        x_s[0] <= pre_x;
        y_s[0] <= pre_y;
        z_s[0] <= pre_z;
        for (int i = 0; i < LAST; i++) begin
            // Turn toward zero residual angle.
            if (z_s[i] >= 0) begin
                x_s[i+1] <= x_s[i] - (y_s[i] >>> i);
                y_s[i+1] <= y_s[i] + (x_s[i] >>> i);
                z_s[i+1] <= z_s[i] - cordic_atan(i);
            end else begin
                x_s[i+1] <= x_s[i] + (y_s[i] >>> i);
                y_s[i+1] <= y_s[i] - (x_s[i] >>> i);
                z_s[i+1] <= z_s[i] + cordic_atan(i);
            end
        end
        o_x <= scale_round(x_last);
        o_y <= scale_round(y_last);
    end

    // Valid travels alongside the data.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            v_s     <= '0;
            o_valid <= 1'b0;
        end else begin
            v_s     <= {v_s[CORDIC_STAGES-2:0], i_valid};
            o_valid <= v_s[LAST];
        end
    end

endmodule

`default_nettype wire

/* coor_result.sv */
`default_nettype none

module coor_result import rot_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_issue,
    input  logic                        i_valid,
    input  logic signed [VEC_WIDTH-1:0] i_x,
    input  logic signed [VEC_WIDTH-1:0] i_y,
    input  logic                        i_res_credit,
    output logic                        o_issue_ok,
    output logic                        o_res_valid,
    output logic [IMAGE_COOR_BIT-1:0]   o_res_h,
    output logic [IMAGE_COOR_BIT-1:0]   o_res_v,
    output logic                        o_res_oor
);

    logic [RES_CNT_BITS-1:0]     credits;
    logic [RES_CNT_BITS-1:0]     reserved;
    logic [RES_CNT_BITS:0]       committed;
    logic signed [VEC_WIDTH:0]   h_wide;
    logic signed [VEC_WIDTH:0]   v_wide;
    logic [IMAGE_COOR_BIT-1:0]   h_clamp;
    logic [IMAGE_COOR_BIT-1:0]   v_clamp;
    logic                        oor;

    // An issue in the current cycle is counted at once, since decode
    // may pop again before the reservation register catches up.
    assign committed  = {1'b0, reserved} + (RES_CNT_BITS+1)'(i_issue);
    assign o_issue_ok = {1'b0, credits} > committed;

    // Back to pixel indices.
    assign h_wide = (VEC_WIDTH+1)'(i_x) + (VEC_WIDTH+1)'(IMAGE_SIZE - 1);
    assign v_wide = (VEC_WIDTH+1)'(IMAGE_SIZE - 1) - (VEC_WIDTH+1)'(i_y);

    always_comb begin
        logic signed [VEC_WIDTH:0] h_half;
        logic signed [VEC_WIDTH:0] v_half;
        h_half = h_wide >>> 1;
        v_half = v_wide >>> 1;
        // Negative indices clamp to zero.
        h_clamp = (h_half < 0) ? '0 : h_half[IMAGE_COOR_BIT-1:0];
        v_clamp = (v_half < 0) ? '0 : v_half[IMAGE_COOR_BIT-1:0];
    end

    assign oor = (i_x >= IMAGE_SIZE) || (i_y >= IMAGE_SIZE) ||
                 (i_x < -IMAGE_SIZE) || (i_y < -IMAGE_SIZE);

    // Credit and reservation counters.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            credits  <= RES_CNT_BITS'(RES_CREDITS);
            reserved <= '0;
        end else begin
            credits  <= credits + RES_CNT_BITS'(i_res_credit) - RES_CNT_BITS'(i_valid);
            reserved <= reserved + RES_CNT_BITS'(i_issue) - RES_CNT_BITS'(i_valid);
        end
    end

    // Result register is the only buffer.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_res_h   <= h_clamp;
            o_res_v   <= v_clamp;
            o_res_oor <= oor;
        end
    end

endmodule

`default_nettype wire

/* image_rotator_top.sv */
`default_nettype none

module image_rotator_top import rot_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_cmd_valid,
    input  rot_op_e                     i_cmd_op,
    input  logic [IMAGE_COOR_BIT-1:0]   i_cmd_h,
    input  logic [IMAGE_COOR_BIT-1:0]   i_cmd_v,
    input  logic signed [ANG_WIDTH-1:0] i_cmd_angle,
    input  logic                        i_res_credit,
    output logic                        o_cmd_credit,
    output logic                        o_res_valid,
    output logic [IMAGE_COOR_BIT-1:0]   o_res_h,
    output logic [IMAGE_COOR_BIT-1:0]   o_res_v,
    output logic                        o_res_oor
);

    logic                        issue;
    logic                        issue_ok;
    logic signed [VEC_WIDTH-1:0] x_in;
    logic signed [VEC_WIDTH-1:0] y_in;
    logic signed [ANG_WIDTH-1:0] angle;
    logic                        rot_valid;
    logic signed [VEC_WIDTH-1:0] x_rot;
    logic signed [VEC_WIDTH-1:0] y_rot;

    coor_decode u_decode (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_h      (i_cmd_h),
        .i_cmd_v      (i_cmd_v),
        .i_cmd_angle  (i_cmd_angle),
        .i_issue_ok   (issue_ok),
        .o_cmd_credit (o_cmd_credit),
        .o_issue      (issue),
        .o_x          (x_in),
        .o_y          (y_in),
        .o_angle      (angle)
    );

    cordic_execute u_execute (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (issue),
        .i_x     (x_in),
        .i_y     (y_in),
        .i_angle (angle),
        .o_valid (rot_valid),
        .o_x     (x_rot),
        .o_y     (y_rot)
    );

    coor_result u_result (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_issue      (issue),
        .i_valid      (rot_valid),
        .i_x          (x_rot),
        .i_y          (y_rot),
        .i_res_credit (i_res_credit),
        .o_issue_ok   (issue_ok),
        .o_res_valid  (o_res_valid),
        .o_res_h      (o_res_h),
        .o_res_v      (o_res_v),
        .o_res_oor    (o_res_oor)
    );

endmodule

`default_nettype wire

/* image_rotator_assertions.sv */
`default_nettype none

module image_rotator_assertions import rot_pkg::*; (
    input logic                    i_clk,
    input logic                    i_rst_n,
    input logic                    i_res_send,
    input logic [RES_CNT_BITS-1:0] i_res_credits,
    input logic                    i_issue,
    input logic                    i_issue_ok,
    input logic                    i_cmd_credit,
    input logic                    i_push,
    input logic                    i_pop,
    input logic [CMD_CNT_BITS-1:0] i_fifo_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // A result only goes out with an output credit in hand.
    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_res_send |-> i_res_credits != '0)
        else $error("result sent with zero output credits");

    // Issue only follows a pop that was allowed.
    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_issue |-> $past(i_issue_ok))
        else $error("issue while issue_ok was low");

    assert property (@(posedge i_clk) !i_rst_n |=> !i_cmd_credit)
        else $error("command credit high after reset");

    // Full FIFO takes a push only together with a pop.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_push && i_fifo_count == CMD_CNT_BITS'(CMD_FIFO_DEPTH)) |-> i_pop)
        else $error("command FIFO overflow");

endmodule

bind coor_result image_rotator_assertions u_result_assert (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_res_send (i_valid), .i_res_credits (credits),
    .i_issue (i_issue), .i_issue_ok (o_issue_ok), .i_cmd_credit (1'b0),
    .i_push (1'b0), .i_pop (1'b0), .i_fifo_count ('0)
);

bind coor_decode image_rotator_assertions u_decode_assert (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_res_send (1'b0), .i_res_credits ('1),
    .i_issue (1'b0), .i_issue_ok (1'b1), .i_cmd_credit (o_cmd_credit),
    .i_push (i_cmd_valid), .i_pop (pop), .i_fifo_count (count)
);

`default_nettype wire

/* tb_image_rotator.sv */
`default_nettype none

module tb_image_rotator import rot_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES = 27;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 2 * (ROT_LATENCY + 8) + 200;
    localparam real PI = 3.14159265358979;

    // Columns are angle, H, V and the expected flag (2 means decided by the model).
    int stim_table [NUM_ENTRIES][4] = '{
        '{0, 0, 0, 0}, '{0, 59, 59, 0}, '{0, 0, 59, 0}, '{0, 59, 0, 0}, '{0, 30, 17, 0},
        '{90, 0, 0, 0}, '{90, 59, 0, 0}, '{90, 30, 59, 0}, '{90, 0, 30, 0},
        '{-90, 59, 59, 0}, '{-90, 0, 59, 0}, '{-90, 17, 44, 0},
        '{180, 0, 0, 0}, '{180, 59, 59, 0}, '{180, 12, 40, 0},
        '{30, 20, 25, 0}, '{-45, 30, 30, 0}, '{-45, 35, 20, 0},
        '{135, 25, 35, 0}, '{135, 40, 28, 0},
        '{45, 0, 0, 1}, '{45, 59, 59, 1}, '{45, 59, 0, 1},
        '{7, 45, 10, 2}, '{-123, 5, 50, 2}, '{179, 33, 3, 2}, '{-180, 10, 50, 2}
    };

    logic                        clk;
    logic                        i_rst_n;
    logic                        i_cmd_valid;
    rot_op_e                     i_cmd_op;
    logic [IMAGE_COOR_BIT-1:0]   i_cmd_h;
    logic [IMAGE_COOR_BIT-1:0]   i_cmd_v;
    logic signed [ANG_WIDTH-1:0] i_cmd_angle;
    logic                        i_res_credit;
    logic                        o_cmd_credit;
    logic                        o_res_valid;
    logic [IMAGE_COOR_BIT-1:0]   o_res_h;
    logic [IMAGE_COOR_BIT-1:0]   o_res_v;
    logic                        o_res_oor;

    int mismatches;
    int other_errors;
    int cmds_sent;
    int credits_back;
    int rotates_sent;
    int results_seen;
    int cycle;
    int exp_h_q [$];
    int exp_v_q [$];
    int exp_oor_q [$];
    int exp_idx_q [$];
    int credit_due [$];

    image_rotator_top u_dut (
        .i_clk        (clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_h      (i_cmd_h),
        .i_cmd_v      (i_cmd_v),
        .i_cmd_angle  (i_cmd_angle),
        .i_res_credit (i_res_credit),
        .o_cmd_credit (o_cmd_credit),
        .o_res_valid  (o_res_valid),
        .o_res_h      (o_res_h),
        .o_res_v      (o_res_v),
        .o_res_oor    (o_res_oor)
    );

    always #50 clk = ~clk;

    // True when c is within 2 units of either image edge.
    function automatic bit near_edge(input real c);
        return ((c - 60.0) < 2.0 && (c - 60.0) > -2.0) ||
               ((c + 60.0) < 2.0 && (c + 60.0) > -2.0);
    endfunction

    // Real-number rotation and back-mapping; -1 marks a value left unchecked.
    task automatic predict(input int idx);
        real th;
        real x;
        real y;
        real xr;
        real yr;
        real hr;
        real vr;
        int  eh;
        int  ev;
        int  eo;
        th = real'(stim_table[idx][0]) * PI / 180.0;
        x  = real'(2 * stim_table[idx][1] + 1 - IMAGE_SIZE);
        y  = real'(IMAGE_SIZE - 1 - 2 * stim_table[idx][2]);
        xr = x * $cos(th) - y * $sin(th);
        yr = x * $sin(th) + y * $cos(th);
        hr = (xr + 59.0) / 2.0;
        vr = (59.0 - yr) / 2.0;
        eh = (hr > 61.0) ? -1 : ((hr < 0.0) ? 0 : int'($floor(hr)));
        ev = (vr > 61.0) ? -1 : ((vr < 0.0) ? 0 : int'($floor(vr)));
        if (stim_table[idx][3] < 2) begin
            eo = stim_table[idx][3];
        end else if (near_edge(xr) || near_edge(yr)) begin
            eo = -1;
        end else begin
            eo = (xr >= 60.0 || xr < -60.0 || yr >= 60.0 || yr < -60.0) ? 1 : 0;
        end
        exp_h_q.push_back(eh);
        exp_v_q.push_back(ev);
        exp_oor_q.push_back(eo);
        exp_idx_q.push_back(idx);
    endtask

    // Waits for an input credit, then drives one command for one cycle.
    task automatic send_cmd(input rot_op_e op, input int angle, input int h, input int v);
        while (CMD_FIFO_DEPTH - cmds_sent + credits_back <= 0) begin
            @(negedge clk);
        end
        i_cmd_valid = 1'b1;
        i_cmd_op    = op;
        i_cmd_h     = IMAGE_COOR_BIT'(h);
        i_cmd_v     = IMAGE_COOR_BIT'(v);
        i_cmd_angle = ANG_WIDTH'(angle);
        cmds_sent++;
        @(negedge clk);
        i_cmd_valid = 1'b0;
    endtask

    // Input credit monitor.
    always @(negedge clk) begin
        if (i_rst_n && o_cmd_credit) begin
            credits_back++;
            if (credits_back > cmds_sent) begin
                other_errors++;
                $display("ERROR: input credit returned with no command outstanding");
            end
        end
    end

    // Result sink with randomly delayed credit return.
    always @(negedge clk) begin
        int eh;
        int ev;
        int eo;
        int idx;
        cycle++;
        i_res_credit = 1'b0;
        if (i_rst_n && o_res_valid) begin
            results_seen++;
            credit_due.push_back(cycle + int'($urandom_range(5, 0)));
            if (exp_h_q.size() == 0) begin
                other_errors++;
                $display("ERROR: result arrived with no rotate command outstanding");
            end else begin
                eh  = exp_h_q.pop_front();
                ev  = exp_v_q.pop_front();
                eo  = exp_oor_q.pop_front();
                idx = exp_idx_q.pop_front();
                if (eh >= 0 && (int'(o_res_h) > eh + 1 || int'(o_res_h) < eh - 1)) begin
                    mismatches++;
                    $display("MISMATCH entry %0d angle %0d H: expected %0d, actual %0d",
                             idx, stim_table[idx][0], eh, o_res_h);
                end
                if (ev >= 0 && (int'(o_res_v) > ev + 1 || int'(o_res_v) < ev - 1)) begin
                    mismatches++;
                    $display("MISMATCH entry %0d angle %0d V: expected %0d, actual %0d",
                             idx, stim_table[idx][0], ev, o_res_v);
                end
                if (eo >= 0 && int'(o_res_oor) != eo) begin
                    mismatches++;
                    $display("MISMATCH entry %0d angle %0d OOR: expected %0d, actual %0d",
                             idx, stim_table[idx][0], eo, o_res_oor);
                end
            end
        end
        // One credit per cycle, oldest due first.
        for (int i = 0; i < credit_due.size(); i++) begin
            if (credit_due[i] <= cycle) begin
                i_res_credit = 1'b1;
                credit_due.delete(i);
                break;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("ERROR: timeout after %0d cycles, results still missing", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(32'h1a73));
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_cmd_valid  = 1'b0;
        i_cmd_op     = OP_SET_ANGLE;
        i_cmd_h      = '0;
        i_cmd_v      = '0;
        i_cmd_angle  = '0;
        i_res_credit = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        if (o_cmd_credit !== 1'b0 || o_res_valid !== 1'b0) begin
            other_errors++;
            $display("ERROR: credit or valid output not low after reset");
        end
        // Back to back, so several rotates share the pipeline.
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            send_cmd(OP_SET_ANGLE, stim_table[i][0], 0, 0);
            predict(i);
            rotates_sent++;
            send_cmd(OP_ROTATE, 0, stim_table[i][1], stim_table[i][2]);
        end
        while (results_seen < rotates_sent || credits_back < cmds_sent) begin
            @(negedge clk);
        end
        // Catch any stray result or credit.
        repeat (ROT_LATENCY + 8) @(negedge clk);
        if (results_seen != rotates_sent) begin
            other_errors++;
            $display("ERROR: %0d results for %0d rotate commands", results_seen, rotates_sent);
        end
        if (credits_back != cmds_sent) begin
            other_errors++;
            $display("ERROR: %0d input credits for %0d commands", credits_back, cmds_sent);
        end
        $display("Errors: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rot_pkg.sv
coor_decode.sv
cordic_execute.sv
coor_result.sv
image_rotator_top.sv
image_rotator_assertions.sv
tb_image_rotator.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the image rotator testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module tb_image_rotator \
    -o sim_image_rotator

./obj_dir/sim_image_rotator | tee sim.log

# Verdict comes from the log.
grep -q '^\*\* PASS \*\*$' sim.log

echo "Simulation passed"
